// File: common/div_defs.svh
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// operand and result width
`define DIV_XLEN 32

// destination register tag width
`define DIV_TAG_W 5

`endif

// File: common/rv_div_pkg.sv
`include "div_defs.svh"

package rv_div_pkg;

    // M extension divide ops, low bit set means unsigned
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_e;

    typedef struct packed {
        div_op_e               op;
        logic [`DIV_TAG_W-1:0] tag;
        logic [`DIV_XLEN-1:0]  dividend;
        logic [`DIV_XLEN-1:0]  divisor;
    } div_req_t;

    typedef struct packed {
        logic [`DIV_TAG_W-1:0] tag;
        logic [`DIV_XLEN-1:0]  result;
    } div_rsp_t;

endpackage

// File: common/div_pipe_pkg.sv
`include "div_defs.svh"

package div_pipe_pkg;

    // payload handed from one divide step to the next
    typedef struct packed {
        logic [`DIV_XLEN-1:0]  rem;      // partial remainder
        logic [`DIV_XLEN-1:0]  dvd;      // dividend, msb consumed each step
        logic [`DIV_XLEN-1:0]  dvs;      // divisor magnitude
        logic [`DIV_XLEN-1:0]  quo;      // quotient bits so far
        logic                  neg_q;
        logic                  neg_r;
        logic                  sel_rem;  // return remainder
        logic                  by_zero;
        logic                  ovf;      // signed overflow
        logic [`DIV_XLEN-1:0]  orig_dvd; // rem result for div by zero
        logic [`DIV_TAG_W-1:0] tag;
    } div_stage_t;

endpackage

// File: divider/div_cell.sv
`timescale 1ns/1ns
`include "div_defs.svh"

module div_cell (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     advance,
    input  logic                     in_valid,
    input  div_pipe_pkg::div_stage_t in_stage,
    output logic                     out_valid,
    output div_pipe_pkg::div_stage_t out_stage
);

    logic [`DIV_XLEN:0]       rem_sh;  // one extra bit, 2*rem+1 can pass 2^32
    logic [`DIV_XLEN:0]       rem_sub;
    logic                     q_bit;
    div_pipe_pkg::div_stage_t nxt;

    assign rem_sh  = {in_stage.rem, in_stage.dvd[`DIV_XLEN-1]};
    assign rem_sub = rem_sh - {1'b0, in_stage.dvs};
    assign q_bit   = (rem_sh >= {1'b0, in_stage.dvs});

    always_comb begin
        nxt     = in_stage;
        nxt.rem = q_bit ? rem_sub[`DIV_XLEN-1:0] : rem_sh[`DIV_XLEN-1:0];
        nxt.dvd = {in_stage.dvd[`DIV_XLEN-2:0], 1'b0};
        nxt.quo = {in_stage.quo[`DIV_XLEN-2:0], q_bit};
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_stage <= nxt;
        end
    end

    // restoring step keeps remainder reduced unless divisor is zero
    a_rem_reduced: assert property (
        @(posedge clk) disable iff (!rstn)
        out_valid |-> (out_stage.rem < out_stage.dvs) || out_stage.by_zero
    );

endmodule

// File: divider/div_array.sv
`timescale 1ns/1ns
`include "div_defs.svh"

module div_array (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     advance,
    input  logic                     s0_valid,
    input  div_pipe_pkg::div_stage_t s0,
    output logic                     sn_valid,
    output div_pipe_pkg::div_stage_t sn
);

    // one cell per quotient bit
    localparam int N_CELLS = `DIV_XLEN;

    logic                     chain_valid [0:N_CELLS];
    div_pipe_pkg::div_stage_t chain_stage [0:N_CELLS];

    assign chain_valid[0] = s0_valid;
    assign chain_stage[0] = s0;

    genvar i;
    generate
        for (i = 0; i < N_CELLS; i++) begin : g_cell
            div_cell u_cell (
                .clk       (clk),
                .rstn      (rstn),
                .advance   (advance),
                .in_valid  (chain_valid[i]),
                .in_stage  (chain_stage[i]),
                .out_valid (chain_valid[i+1]),
                .out_stage (chain_stage[i+1])
            );
        end
    endgenerate

    assign sn_valid = chain_valid[N_CELLS];
    assign sn       = chain_stage[N_CELLS]; // all bits resolved here

endmodule

// File: source/div_issue.sv
`timescale 1ns/1ns
`include "div_defs.svh"

module div_issue (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  rv_div_pkg::div_req_t     req,
    input  logic                     advance,
    output logic                     s0_valid,
    output div_pipe_pkg::div_stage_t s0
);

    localparam logic [`DIV_XLEN-1:0] MOST_NEG = {1'b1, {(`DIV_XLEN-1){1'b0}}};

    logic                     is_signed;
    logic                     dvd_neg;
    logic                     dvs_neg;
    logic [`DIV_XLEN-1:0]     dvd_mag;
    logic [`DIV_XLEN-1:0]     dvs_mag;
    div_pipe_pkg::div_stage_t s0_next;

    assign req_ready = advance; // single global stall

    assign is_signed = (req.op == rv_div_pkg::DIV) || (req.op == rv_div_pkg::REM);
    assign dvd_neg   = is_signed && req.dividend[`DIV_XLEN-1];
    assign dvs_neg   = is_signed && req.divisor[`DIV_XLEN-1];
    assign dvd_mag   = dvd_neg ? (~req.dividend + 1'b1) : req.dividend;
    assign dvs_mag   = dvs_neg ? (~req.divisor + 1'b1) : req.divisor;

    always_comb begin
        s0_next          = '0;
        s0_next.rem      = '0;
        s0_next.dvd      = dvd_mag;
        s0_next.dvs      = dvs_mag;
        s0_next.quo      = '0;
        s0_next.neg_q    = dvd_neg ^ dvs_neg;
        s0_next.neg_r    = dvd_neg; // remainder follows dividend sign
        s0_next.sel_rem  = (req.op == rv_div_pkg::REM) || (req.op == rv_div_pkg::REMU);
        s0_next.by_zero  = (req.divisor == '0);
        s0_next.ovf      = is_signed && (req.dividend == MOST_NEG) && (&req.divisor);
        s0_next.orig_dvd = req.dividend;
        s0_next.tag      = req.tag;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s0_valid <= 1'b0;
        end else if (advance) begin
            s0_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s0 <= s0_next;
        end
    end

    // first stage must freeze with the rest of the pipe
    a_s0_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        !advance |=> $stable(s0_valid) && (!s0_valid || $stable(s0))
    );

endmodule

// File: source/div_writeback.sv
`timescale 1ns/1ns
`include "div_defs.svh"

module div_writeback (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     sn_valid,
    input  div_pipe_pkg::div_stage_t sn,
    output logic                     advance,
    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output rv_div_pkg::div_rsp_t     rsp
);

    localparam logic [`DIV_XLEN-1:0] MOST_NEG = {1'b1, {(`DIV_XLEN-1){1'b0}}};

    logic [`DIV_XLEN-1:0] quo_fix;
    logic [`DIV_XLEN-1:0] rem_fix;
    logic [`DIV_XLEN-1:0] result;

    assign quo_fix = sn.neg_q ? (~sn.quo + 1'b1) : sn.quo;
    assign rem_fix = sn.neg_r ? (~sn.rem + 1'b1) : sn.rem;

    always_comb begin
        if (sn.by_zero) begin
            result = sn.sel_rem ? sn.orig_dvd : '1; // RISC-V div by zero
        end else if (sn.ovf) begin
            result = sn.sel_rem ? '0 : MOST_NEG;
        end else begin
            result = sn.sel_rem ? rem_fix : quo_fix;
        end
    end

    // whole pipe moves when output slot frees up
    assign advance = !rsp_valid || rsp_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rsp_valid <= 1'b0;
        end else if (advance) begin
            rsp_valid <= sn_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            rsp.tag    <= sn.tag;
            rsp.result <= result;
        end
    end

    // response held until the consumer takes it
    a_rsp_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
    );

endmodule

// File: source/div_unit.sv
`timescale 1ns/1ns

module div_unit (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  rv_div_pkg::div_req_t req,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output rv_div_pkg::div_rsp_t rsp
);

    logic                     advance;
    logic                     s0_valid;
    div_pipe_pkg::div_stage_t s0;
    logic                     sn_valid;
    div_pipe_pkg::div_stage_t sn;

    div_issue u_issue (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .advance   (advance),
        .s0_valid  (s0_valid),
        .s0        (s0)
    );

    // 32 restoring steps
    div_array u_array (
        .clk      (clk),
        .rstn     (rstn),
        .advance  (advance),
        .s0_valid (s0_valid),
        .s0       (s0),
        .sn_valid (sn_valid),
        .sn       (sn)
    );

    div_writeback u_writeback (
        .clk       (clk),
        .rstn      (rstn),
        .sn_valid  (sn_valid),
        .sn        (sn),
        .advance   (advance),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

endmodule

// File: sim/div_tb.sv
`timescale 1ns/1ns
`include "div_defs.svh"

module div_tb;

    localparam int N_UNS   = 40;
    localparam int N_SGN   = 40;
    localparam int N_ZERO  = 4;
    localparam int N_OVF   = 2;
    localparam int N_MIX   = 80;
    localparam int N_REQ   = N_UNS + N_SGN + N_ZERO + N_OVF + N_MIX + 1;
    localparam int LATENCY = 34;
    localparam int WD_CYC  = N_REQ * 40 + 200;
    localparam logic [`DIV_XLEN-1:0] MOST_NEG = {1'b1, {(`DIV_XLEN-1){1'b0}}};

    logic                  clk;
    logic                  rstn;
    logic                  req_valid;
    logic                  req_ready;
    rv_div_pkg::div_req_t  req;
    logic                  rsp_valid;
    logic                  rsp_ready;
    rv_div_pkg::div_rsp_t  rsp;

    logic [31:0]           lfsr = 32'ha9bf;
    logic                  ready_random = 1'b0;
    logic [`DIV_TAG_W-1:0] next_tag = '0;
    int                    cycle = 0;
    string                 pend_name = "";
    rv_div_pkg::div_rsp_t  exp_q [$];
    string                 name_q [$];

    div_unit dut (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial clk = 1'b0;

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1; // edges seen so far
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // RISC-V M extension divide semantics
    function automatic logic [`DIV_XLEN-1:0] model_result(
        input rv_div_pkg::div_op_e  op,
        input logic [`DIV_XLEN-1:0] a,
        input logic [`DIV_XLEN-1:0] b
    );
        logic signed [`DIV_XLEN-1:0] sa;
        logic signed [`DIV_XLEN-1:0] sb;
        logic [`DIV_XLEN-1:0]        r;
        sa = a;
        sb = b;
        r  = '0;
        case (op)
            rv_div_pkg::DIV: begin
                if (b == '0) begin
                    r = '1;
                end else if (a == MOST_NEG && b == '1) begin
                    r = MOST_NEG;
                end else begin
                    r = sa / sb; // truncates toward zero
                end
            end
            rv_div_pkg::REM: begin
                if (b == '0) begin
                    r = a;
                end else if (a == MOST_NEG && b == '1) begin
                    r = '0;
                end else begin
                    r = sa % sb; // sign of dividend
                end
            end
            rv_div_pkg::DIVU: begin
                r = (b == '0) ? '1 : a / b;
            end
            rv_div_pkg::REMU: begin
                r = (b == '0) ? a : a % b;
            end
        endcase
        return r;
    endfunction

    task automatic compare_result(input string name, input rv_div_pkg::div_rsp_t want,
                                  input rv_div_pkg::div_rsp_t got);
        if (got.result !== want.result) begin
            $display("FAILED %s: expected result %h, actual %h", name, want.result, got.result);
            $display("** FAIL **");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic compare_tag(input string name, input rv_div_pkg::div_rsp_t want,
                               input rv_div_pkg::div_rsp_t got);
        if (got.tag !== want.tag) begin
            $display("FAILED %s: expected tag %h, actual %h", name, want.tag, got.tag);
            $display("** FAIL **");
            $fatal(1, "tag mismatch");
        end
    endtask

    task automatic compare_latency(input string name, input int want, input int got);
        if (got != want) begin
            $display("FAILED %s: expected %0d cycles, actual %0d", name, want, got);
            $display("** FAIL **");
            $fatal(1, "latency mismatch");
        end
    endtask

    // check responses before logging the request taken at this edge
    always @(negedge clk) begin
        rv_div_pkg::div_rsp_t want;
        string                name;
        if (rstn && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("response with tag %h arrived with no request outstanding", rsp.tag);
                $display("** FAIL **");
                $fatal(1, "stray response");
            end else begin
                want = exp_q.pop_front();
                name = name_q.pop_front();
                compare_tag(name, want, rsp);
                compare_result(name, want, rsp);
            end
        end
        if (rstn && req_valid && req_ready) begin
            want.tag    = req.tag;
            want.result = model_result(req.op, req.dividend, req.divisor);
            exp_q.push_back(want);
            name_q.push_back(pend_name);
        end
    end

    task automatic tick();
        @(posedge clk);
        if (ready_random) begin
            rsp_ready <= (take_bits(1) != '0);
        end else begin
            rsp_ready <= 1'b1;
        end
    endtask

    // called right after a rising edge and returns on the accepting edge
    task automatic send_req(input string name, input rv_div_pkg::div_op_e op,
                            input logic [`DIV_XLEN-1:0] a, input logic [`DIV_XLEN-1:0] b,
                            input int gap, output int acc_cycle);
        bit taken;
        if (gap > 0) begin
            req_valid <= 1'b0;
            repeat (gap) tick();
        end
        req_valid    <= 1'b1;
        req.op       <= op;
        req.tag      <= next_tag;
        req.dividend <= a;
        req.divisor  <= b;
        pend_name = name;
        next_tag  = next_tag + 1'b1;
        taken     = 1'b0;
        acc_cycle = 0;
        while (!taken) begin
            @(negedge clk);
            taken     = req_ready;
            acc_cycle = cycle + 1;
            tick();
        end
    endtask

    task automatic drain();
        req_valid <= 1'b0;
        do begin
            tick();
        end while (exp_q.size() != 0);
    endtask

    initial begin
        int                   acc;
        int                   seen;
        logic [31:0]          r;
        logic [`DIV_XLEN-1:0] a;
        logic [`DIV_XLEN-1:0] b;
        rv_div_pkg::div_op_e  op;
        rstn      <= 1'b0;
        req_valid <= 1'b0;
        req       <= '0;
        rsp_ready <= 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        tick();

        // divisor scaled down so quotients spread out
        for (int i = 0; i < N_UNS; i++) begin
            op = (take_bits(1) != '0) ? rv_div_pkg::REMU : rv_div_pkg::DIVU;
            a  = take_bits(32);
            b  = take_bits(32) >> take_bits(5);
            send_req("unsigned", op, a, b, 0, acc);
        end

        for (int i = 0; i < N_SGN; i++) begin
            op = (take_bits(1) != '0) ? rv_div_pkg::REM : rv_div_pkg::DIV;
            a  = take_bits(31) >> take_bits(4);
            b  = take_bits(31) >> take_bits(4);
            if (b == '0) begin
                b = 32'd1;
            end
            if (i[0]) begin
                a = -a;
            end
            if (i[1]) begin
                b = -b;
            end
            send_req("signed", op, a, b, 0, acc);
        end

        for (int k = 0; k < N_ZERO; k++) begin
            r  = k;
            op = rv_div_pkg::div_op_e'(r[1:0]);
            send_req("div by zero", op, take_bits(32), '0, 0, acc);
        end

        send_req("overflow", rv_div_pkg::DIV, MOST_NEG, '1, 0, acc);
        send_req("overflow", rv_div_pkg::REM, MOST_NEG, '1, 0, acc);

        ready_random = 1'b1; // back-pressure from here on
        for (int i = 0; i < N_MIX; i++) begin
            r  = take_bits(2);
            op = rv_div_pkg::div_op_e'(r[1:0]);
            a  = take_bits(32);
            b  = take_bits(32) >> take_bits(5);
            send_req("gaps and stalls", op, a, b, take_bits(2), acc);
        end
        ready_random = 1'b0;
        drain();

        // empty pipe with rsp_ready high
        send_req("latency", rv_div_pkg::DIVU, 32'd1000, 32'd7, 0, acc);
        req_valid <= 1'b0;
        seen = 0;
        while (seen == 0) begin
            @(negedge clk);
            if (rsp_valid) begin
                seen = cycle + 1; // edge that takes the response
            end
        end
        compare_latency("latency", LATENCY, seen - acc);
        drain();

        repeat (LATENCY + 4) tick();
        @(negedge clk);
        if (exp_q.size() == 0 && !rsp_valid) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("responses still outstanding at the end of the run");
            $display("** FAIL **");
            $fatal(1, "leftover responses");
        end
    end

    initial begin
        repeat (WD_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, the divider stopped responding", WD_CYC);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

endmodule

// File: list.f
+incdir+common
common/rv_div_pkg.sv
common/div_pipe_pkg.sv
divider/div_cell.sv
divider/div_array.sv
source/div_issue.sv
source/div_writeback.sv
source/div_unit.sv
sim/div_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := div_tb
FLIST    := list.f
OBJ_DIR  := obj_dir
PASS_MSG := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the divider testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
